// File: build.f
design/ov7670_pkg.sv
design/ov7670_reg_rom.sv
design/ov7670_xclk_gen.sv
design/ov7670_delay_timer.sv
design/ov7670_init_ctrl.sv
design/ov7670_init_top.sv
testbench/tb_clk_gen.sv
testbench/ov7670_init_asserts.sv
testbench/tb_ov7670_init.sv

// File: design/ov7670_delay_timer.sv
//--------------------------------------------------
// Shared delay timer
// Times the reset, wake-up wait and write hold
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ov7670_delay_timer (
  input  logic rst,        // System clock
  input  logic clk,        // Async reset, active high
  input  logic delay_en,   // Count while high
  output logic delay_end   // Terminal count reached
);

  import ov7670_pkg::*;

  logic [DELAY_W-1:0] delay_cnt;

  assign delay_end = (delay_cnt == DELAY_CYCLES);

  // Held at zero when idle so every phase starts fresh
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      delay_cnt <= '0;
    end else if (!delay_en) begin
      delay_cnt <= '0;
    end else if (delay_end) begin
      delay_cnt <= '0;  // Wrap for back to back phases
    end else begin
      delay_cnt <= delay_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/ov7670_init_ctrl.sv
//--------------------------------------------------
// OV7670 start-up sequencer
// State machine, table index counter
// and configuration change detection
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ov7670_init_ctrl (
  input  logic                         rst,         // System clock
  input  logic                         clk,         // Async reset, active high
  input  logic                         sccb_ready,  // SCCB master idle
  input  logic                         test_mode,   // Single step mode
  input  logic                         test_send,   // Step request in test mode
  input  logic                         resend,      // Replay the table
  input  logic                         cfg_sel,     // Table select
  input  ov7670_pkg::reg_entry_t       entry,       // Current ROM entry
  input  logic                         delay_end,   // Timer terminal count
  output logic [ov7670_pkg::IDX_W-1:0] rom_idx,     // Table index
  output logic                         delay_en,    // Timer enable
  output logic                         start_tx,    // One write to the master
  output logic                         done,        // Finish marker reached
  output logic                         cam_rst_n    // Camera reset, active low
);

  import ov7670_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic        cfg_sel_q;   // Previous select
  logic        cfg_change;  // Select moved since last cycle

  // Finish marker has no real register behind it
  assign done       = (entry.addr[7:4] == FINISH_NIBBLE);
  assign cfg_change = cfg_sel ^ cfg_sel_q;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cfg_sel_q <= 1'b0;
    end else begin
      cfg_sel_q <= cfg_sel;
    end
  end

  //--------------------------------------------------
  // Table index

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rom_idx <= '0;
    end else if (resend || cfg_change) begin
      rom_idx <= '0;  // Start the table again
    end else if (start_tx) begin
      rom_idx <= rom_idx + 1'b1;  // Next entry once this one is taken
    end
  end

  //--------------------------------------------------
  // Sequencing FSM

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= RSTCAM_ST;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    start_tx  = 1'b0;
    cam_rst_n = 1'b1;  // Camera runs unless held
    delay_en  = 1'b0;
    case (state)
      RSTCAM_ST: begin
        cam_rst_n = 1'b0;
        delay_en  = 1'b1;
        if (delay_end) state_nxt = WAIT_RSTCAM_ST;
      end
      WAIT_RSTCAM_ST: begin  // Camera wakes up
        delay_en = 1'b1;
        if (delay_end) state_nxt = WAIT_ST;
      end
      WAIT_ST: begin
        if (done) begin
          state_nxt = DONE_ST;
        end else if (sccb_ready && (!test_mode || test_send)) begin
          start_tx  = 1'b1;  // Entry is valid this cycle
          state_nxt = WRITE_REG_ST;
        end
      end
      WRITE_REG_ST: begin  // Let the write settle
        delay_en = 1'b1;
        if (delay_end) state_nxt = WAIT_ST;
      end
      DONE_ST: begin
        // Index was cleared by a restart, run the full bring-up again
        if (!done) state_nxt = RSTCAM_ST;
      end
      default: state_nxt = RSTCAM_ST;
    endcase
  end

endmodule

`default_nettype wire

// File: design/ov7670_init_top.sv
//--------------------------------------------------
// OV7670 start-up controller top level
// Sequencer, register ROM, delay timer
// and camera clock generator
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ov7670_init_top (
  input  logic                   rst,         // System clock
  input  logic                   clk,         // Async reset, active high
  input  logic                   sccb_ready,  // SCCB master idle
  input  logic                   test_mode,   // Single step mode
  input  logic                   test_send,   // Step request
  input  logic                   resend,      // Replay the table
  input  logic                   cfg_sel,     // Table select
  output logic                   start_tx,    // Write strobe to the master
  output ov7670_pkg::reg_entry_t sccb_cmd,    // Address and data to write
  output logic                   done,        // All writes issued
  output logic                   cam_rst_n,   // Camera reset, active low
  output logic                   cam_xclk     // Camera system clock
);

  import ov7670_pkg::*;

  logic [IDX_W-1:0] rom_idx;
  reg_entry_t       entry;
  logic             delay_en;
  logic             delay_end;

  assign sccb_cmd = entry;

  ov7670_init_ctrl ov7670_init_ctrl_inst (
    .rst        (rst),
    .clk        (clk),
    .sccb_ready (sccb_ready),
    .test_mode  (test_mode),
    .test_send  (test_send),
    .resend     (resend),
    .cfg_sel    (cfg_sel),
    .entry      (entry),
    .delay_end  (delay_end),
    .rom_idx    (rom_idx),
    .delay_en   (delay_en),
    .start_tx   (start_tx),
    .done       (done),
    .cam_rst_n  (cam_rst_n)
  );

  ov7670_reg_rom ov7670_reg_rom_inst (
    .rst     (rst),
    .clk     (clk),
    .cfg_sel (cfg_sel),
    .rom_idx (rom_idx),
    .entry   (entry)
  );

  // One timer serves every delay phase
  ov7670_delay_timer ov7670_delay_timer_inst (
    .rst       (rst),
    .clk       (clk),
    .delay_en  (delay_en),
    .delay_end (delay_end)
  );

  ov7670_xclk_gen ov7670_xclk_gen_inst (
    .rst      (rst),
    .clk      (clk),
    .cam_xclk (cam_xclk)
  );

endmodule

`default_nettype wire

// File: design/ov7670_pkg.sv
//--------------------------------------------------
// OV7670 start-up controller shared definitions
// Timing and table constants, register entry type
// and the controller state encoding
//--------------------------------------------------
`default_nettype none

package ov7670_pkg;

  //--------------------------------------------------
  // Delay timing

  localparam int DELAY_W = 25;  // Wide enough for a 300 ms count at 100 MHz
  // Terminal count, each delay phase is DELAY_CYCLES+1 cycles
  localparam logic [DELAY_W-1:0] DELAY_CYCLES = 25'd3000;

  //--------------------------------------------------
  // Camera system clock

  localparam int XCLK_DIV = 4;                  // 100 MHz in, 25 MHz out
  localparam int XCLK_W   = $clog2(XCLK_DIV);   // Divider counter width

  //--------------------------------------------------
  // Register table

  localparam int IDX_W = 6;  // Tables hold fewer than 64 writes

  // One SCCB register write, address in the upper byte
  typedef struct packed {
    logic [7:0] addr;  // Camera register address
    logic [7:0] data;  // Value to write
  } reg_entry_t;

  // Read-only product id register, writing it has no effect
  localparam reg_entry_t NOP_ENTRY   = 16'h0A76;
  localparam reg_entry_t RESET_ENTRY = 16'h1280;  // COM7 soft reset

  // No camera register lives at 0xF0..0xFF, so this marks the end
  localparam logic [3:0] FINISH_NIBBLE = 4'hF;

  // Camera write id, for the SCCB master (0x42 with the R/W bit)
  localparam logic [6:0] SCCB_WRITE_ID = 7'h21;

  //--------------------------------------------------
  // Controller states

  typedef enum logic [2:0] {
    RSTCAM_ST,       // Camera held in reset
    WAIT_RSTCAM_ST,  // Wake-up wait after reset release
    WAIT_ST,         // Waiting for the SCCB master
    WRITE_REG_ST,    // Hold after a write was issued
    DONE_ST          // Whole table written
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: design/ov7670_reg_rom.sv
//--------------------------------------------------
// OV7670 register tables
// Table 0: QQVGA RGB
// Table 1: QQVGA/2 RGB444 with colour bar
// Registered read, maps to block memory
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ov7670_reg_rom (
  input  logic                         rst,      // System clock
  input  logic                         clk,      // Async reset, active high
  input  logic                         cfg_sel,  // Table select
  input  logic [ov7670_pkg::IDX_W-1:0] rom_idx,  // Entry index
  output ov7670_pkg::reg_entry_t       entry     // Registered table entry
);

  import ov7670_pkg::*;

  reg_entry_t tbl0;  // Table 0 entry at rom_idx
  reg_entry_t tbl1;  // Table 1 entry at rom_idx

  // Table 0, QQVGA RGB
  always_comb begin
    case (rom_idx)
      6'h00:   tbl0 = 16'h1280;  // COM7 reset all registers
      6'h01:   tbl0 = 16'h1280;  // Repeated to be safe
      6'h02:   tbl0 = 16'h1181;  // CLKRC internal clock /2
      6'h03:   tbl0 = 16'h1204;  // COM7 RGB output
      6'h04:   tbl0 = 16'h0C04;  // COM3 scaling enable
      6'h05:   tbl0 = 16'h3E1A;  // COM14 manual scaling, PCLK /4
      6'h06:   tbl0 = 16'h703A;  // SCALING_XSC
      6'h07:   tbl0 = 16'h7135;  // SCALING_YSC
      6'h08:   tbl0 = 16'h7233;  // SCALING_DCWCTR
      6'h09:   tbl0 = 16'h73F3;  // SCALING_PCLK_DIV
      6'h0A:   tbl0 = 16'hA202;  // SCALING_PCLK_DELAY
      // Padding, same value rewritten
      6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F, 6'h10,
      6'h11, 6'h12, 6'h13, 6'h14, 6'h15:
               tbl0 = 16'hA202;
      6'h16:   tbl0 = 16'h40F0;  // COM15 full range
      6'h17:   tbl0 = 16'h0F43;  // COM6
      6'h18:   tbl0 = 16'h8C02;  // RGB444 enable
      6'h19:   tbl0 = 16'h1520;  // COM10 no PCLK in blanking
      6'h1A:   tbl0 = 16'h0E61;  // COM5
      6'h1B:   tbl0 = 16'h0F4B;  // COM6
      6'h1C:   tbl0 = 16'h1602;  // Reserved register
      6'h1D:   tbl0 = 16'hFFFF;  // End of table
      default: tbl0 = NOP_ENTRY;
    endcase
  end

  // Table 1, QQVGA/2 RGB444 with 8-bar colour test pattern
  always_comb begin
    case (rom_idx)
      6'h00:   tbl1 = 16'h1280;  // COM7 reset all registers
      6'h01:   tbl1 = 16'h1280;
      6'h02:   tbl1 = 16'h1204;  // COM7 RGB output
      6'h03:   tbl1 = 16'h40F0;  // COM15 full range, RGB444 path
      6'h04:   tbl1 = 16'h8C02;  // RGB444 enable, xR GB
      6'h05:   tbl1 = 16'h1181;  // CLKRC internal clock /2
      6'h06:   tbl1 = 16'h0F43;  // COM6 reset timing on format change
      6'h07:   tbl1 = 16'h1520;  // COM10 HREF, PCLK quiet in blanking
      6'h08:   tbl1 = 16'h0C04;  // COM3 scaling enable
      6'h09:   tbl1 = 16'h3E1B;  // COM14 PCLK /8
      6'h0A:   tbl1 = 16'h703A;  // SCALING_XSC, test pattern bit 0 low
      6'h0B:   tbl1 = 16'h71B5;  // SCALING_YSC, test pattern bit 1 high
      6'h0C:   tbl1 = 16'h7233;  // DCW down sample by 8 both ways
      6'h0D:   tbl1 = 16'h73F3;  // SCALING_PCLK_DIV /8
      6'h0E:   tbl1 = 16'hA202;  // SCALING_PCLK_DELAY
      default: tbl1 = 16'hFFFF;  // End of table, also past the end
    endcase
  end

  // Registered output stage
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      entry <= RESET_ENTRY;
    end else begin
      entry <= cfg_sel ? tbl1 : tbl0;
    end
  end

endmodule

`default_nettype wire

// File: design/ov7670_xclk_gen.sv
//--------------------------------------------------
// Camera system clock divider
// Wrapping counter, top bit is the clock
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ov7670_xclk_gen (
  input  logic rst,       // System clock
  input  logic clk,       // Async reset, active high
  output logic cam_xclk   // Camera system clock, 50% duty
);

  import ov7670_pkg::*;

  logic [XCLK_W-1:0] div_cnt;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      div_cnt <= '0;
    end else if (div_cnt == XCLK_W'(XCLK_DIV - 1)) begin
      div_cnt <= '0;  // Wrap
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign cam_xclk = div_cnt[XCLK_W-1];  // Low for half, high for half

endmodule

`default_nettype wire

// File: testbench/ov7670_init_asserts.sv
//--------------------------------------------------
// Concurrent checks on the sequencer write strobe
// Bound into every ov7670_init_ctrl instance
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ov7670_init_asserts (
  input logic rst,         // System clock
  input logic clk,         // Async reset, active high
  input logic start_tx,    // Write strobe
  input logic sccb_ready,  // SCCB master idle
  input logic done,        // Finish marker reached
  input logic cam_rst_n    // Camera reset, active low
);

  // FSM leaves WAIT_ST on the strobe, so it never repeats
  start_single_cycle: assert property (
    @(posedge rst) disable iff (clk) start_tx |=> !start_tx
  ) else $error("start_tx high for more than one cycle");

  start_only_when_ready: assert property (
    @(posedge rst) disable iff (clk) start_tx |-> (sccb_ready && !done)
  ) else $error("start_tx while the master is busy or the table is done");

  // Writes only go out to a running camera
  start_camera_running: assert property (
    @(posedge rst) disable iff (clk) start_tx |-> cam_rst_n
  ) else $error("start_tx while the camera is held in reset");

endmodule

bind ov7670_init_ctrl ov7670_init_asserts ov7670_init_asserts_inst (
  .rst        (rst),
  .clk        (clk),
  .start_tx   (start_tx),
  .sccb_ready (sccb_ready),
  .done       (done),
  .cam_rst_n  (cam_rst_n)
);

`default_nettype wire

// File: testbench/tb_clk_gen.sv
//--------------------------------------------------
// Testbench clock and reset source
// 20 ns clock, reset held for 16 cycles
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic rst,  // System clock
  output logic clk   // Async reset, active high
);

  localparam int HALF_NS      = 10;  // Half of the 20 ns period
  localparam int RESET_CYCLES = 16;

  initial begin
    rst = 1'b0;
    forever #(HALF_NS) rst = ~rst;
  end

  // Release lands on a falling edge, away from the sampling edge
  initial begin
    clk = 1'b1;
    repeat (RESET_CYCLES) @(negedge rst);
    clk = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_ov7670_init.sv
//--------------------------------------------------
// Testbench for the OV7670 start-up controller
// Directed tests, expected register tables,
// write monitor and watchdog
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ov7670_init;

  import ov7670_pkg::*;

  localparam int PERIOD_NS    = 20;
  localparam int PHASE_CYCLES = 3001;  // Reset, wake-up wait and write hold
  localparam int TBL0_WRITES  = 29;    // Entries before the finish marker
  localparam int TBL1_WRITES  = 15;
  localparam int TOTAL_WRITES = 3 * TBL0_WRITES + 2 * TBL1_WRITES;
  // Every write plus the delay phases, with room to spare
  localparam int WATCHDOG_NS  = (TOTAL_WRITES + 6 + 16) * (PHASE_CYCLES + 1) * PERIOD_NS;

  logic       rst;         // Clock
  logic       clk;         // Reset
  logic       sccb_ready;
  logic       test_mode;
  logic       test_send;
  logic       resend;
  logic       cfg_sel;
  logic       start_tx;
  reg_entry_t sccb_cmd;
  logic       done;
  logic       cam_rst_n;
  logic       cam_xclk;

  logic [15:0] tbl0 [0:29];  // QQVGA RGB
  logic [15:0] tbl1 [0:15];  // QQVGA/2 RGB444 colour bar
  logic [15:0] writes [$];   // Commands seen on start_tx
  int          errors = 0;
  integer      seed = 32'hf5953d82;
  integer      rnd;
  logic        random_ready = 1'b0;  // Back-pressure on
  logic        start_q = 1'b0;

  tb_clk_gen tb_clk_gen_inst (
    .rst (rst),
    .clk (clk)
  );

  ov7670_init_top ov7670_init_top_inst (
    .rst        (rst),
    .clk        (clk),
    .sccb_ready (sccb_ready),
    .test_mode  (test_mode),
    .test_send  (test_send),
    .resend     (resend),
    .cfg_sel    (cfg_sel),
    .start_tx   (start_tx),
    .sccb_cmd   (sccb_cmd),
    .done       (done),
    .cam_rst_n  (cam_rst_n),
    .cam_xclk   (cam_xclk)
  );

  //--------------------------------------------------
  // Write monitor and random ready

  always @(posedge rst) begin
    if (start_tx) begin
      writes.push_back(sccb_cmd);  // Command valid in the strobe cycle
    end
    if (start_tx && (!sccb_ready || done || !cam_rst_n)) begin
      errors++;
      $display("start_tx issued while sccb_ready low, done high or camera in reset");
    end
    if (start_tx && start_q) begin
      errors++;
      $display("start_tx held for more than one cycle");
    end
    start_q <= start_tx;
  end

  always @(negedge rst) begin
    if (random_ready) begin
      rnd = $random(seed);
      sccb_ready = rnd[0];
    end
  end

  //--------------------------------------------------
  // Helpers

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
  endtask

  task automatic pulse_resend();
    @(negedge rst);
    resend = 1'b1;
    @(negedge rst);
    resend = 1'b0;
  endtask

  // Waits for cam_rst_n to fall, then measures how long it stays low
  task automatic check_reset_phase();
    int n;
    int low;
    n = 0;
    low = 0;
    @(posedge rst);
    while (cam_rst_n && n < 8) begin
      n++;
      @(posedge rst);
    end
    if (cam_rst_n) begin
      errors++;
      $display("camera reset was not asserted after the restart");
    end else begin
      while (!cam_rst_n && low <= PHASE_CYCLES) begin
        low++;
        @(posedge rst);
      end
      if (low != PHASE_CYCLES) report_mismatch("cam_rst_n low cycles", low, PHASE_CYCLES);
    end
  endtask

  // Find a rising sample, then expect two high and two low
  task automatic check_xclk();
    int   j;
    logic prev;
    j = 0;
    prev = 1'b1;
    @(posedge rst);
    while (!(cam_xclk && !prev) && j < 8) begin
      prev = cam_xclk;
      j++;
      @(posedge rst);
    end
    if (j == 8) begin
      errors++;
      $display("cam_xclk did not toggle after reset");
    end else begin
      for (j = 0; j < 8; j++) begin
        if (cam_xclk !== ((j % 4) < 2)) report_mismatch("cam_xclk", cam_xclk, (j % 4) < 2);
        @(posedge rst);
      end
    end
  endtask

  task automatic compare_writes(input logic cfg, input int n_writes);
    int          i;
    logic [15:0] exp;
    if (writes.size() != n_writes) report_mismatch("write count", writes.size(), n_writes);
    for (i = 0; i < n_writes && i < writes.size(); i++) begin
      exp = cfg ? tbl1[i] : tbl0[i];
      if (writes[i] !== exp) report_mismatch("sccb_cmd", writes[i], exp);
    end
  endtask

  // Runs until done, then through the last hold with no more writes
  task automatic finish_table(input logic cfg, input int n_writes);
    int k;
    k = 0;
    @(posedge rst);
    while (!done && k < (n_writes + 3) * 2 * (PHASE_CYCLES + 1)) begin
      k++;
      @(posedge rst);
    end
    if (!done) begin
      errors++;
      $display("done did not rise after the table was sent");
    end
    repeat (PHASE_CYCLES + 4) @(posedge rst);
    if (done !== 1'b1) report_mismatch("done", done, 1);
    compare_writes(cfg, n_writes);
  endtask

  //--------------------------------------------------
  // Tests

  task automatic test_reset_and_xclk();
    int n;
    repeat (4) @(posedge rst);  // Still in reset
    if ({start_tx, done, cam_rst_n, cam_xclk} !== 4'b0000)
      report_mismatch("{start_tx,done,cam_rst_n,cam_xclk}",
                      {start_tx, done, cam_rst_n, cam_xclk}, 0);
    @(negedge clk);
    fork
      check_xclk();
      begin
        check_reset_phase();
        n = 0;
        while (!start_tx && n <= 2 * PHASE_CYCLES) begin
          n++;
          @(posedge rst);
        end
        // Wake-up wait sits between reset release and the first write
        if (n != PHASE_CYCLES) report_mismatch("start_tx delay after reset", n, PHASE_CYCLES);
      end
    join
  endtask

  task automatic test_cfg0_sequence();
    finish_table(1'b0, TBL0_WRITES);  // First write already in the queue
  endtask

  task automatic test_cfg_change();
    writes.delete();
    @(negedge rst);
    cfg_sel = 1'b1;
    check_reset_phase();
    finish_table(1'b1, TBL1_WRITES);
  endtask

  task automatic test_single_step();
    int k;
    writes.delete();
    @(negedge rst);
    test_mode = 1'b1;
    pulse_resend();
    check_reset_phase();
    repeat (PHASE_CYCLES + 8) @(posedge rst);  // Idle in WAIT_ST by now
    if (writes.size() != 0) report_mismatch("write count without test_send", writes.size(), 0);
    for (k = 0; k < 3; k++) begin
      @(negedge rst);
      test_send = 1'b1;
      @(negedge rst);
      test_send = 1'b0;
      repeat (PHASE_CYCLES + 4) @(posedge rst);  // Hold ends, waiting again
      if (writes.size() != k + 1)
        report_mismatch("write count in test mode", writes.size(), k + 1);
      else if (writes[k] !== tbl1[k])
        report_mismatch("sccb_cmd", writes[k], tbl1[k]);
    end
    @(negedge rst);
    test_mode = 1'b0;
    finish_table(1'b1, TBL1_WRITES);
  endtask

  task automatic test_back_pressure();
    writes.delete();
    @(negedge rst);
    cfg_sel      = 1'b0;  // Back to table 0
    random_ready = 1'b1;
    check_reset_phase();
    finish_table(1'b0, TBL0_WRITES);
    @(negedge rst);
    random_ready = 1'b0;
    sccb_ready   = 1'b1;
  endtask

  task automatic test_resend();
    if (done !== 1'b1) report_mismatch("done before resend", done, 1);
    writes.delete();
    pulse_resend();
    check_reset_phase();
    if (done !== 1'b0) report_mismatch("done after resend", done, 0);
    finish_table(1'b0, TBL0_WRITES);
  endtask

  //--------------------------------------------------
  // Main sequence and watchdog

  initial begin
    sccb_ready = 1'b1;
    test_mode  = 1'b0;
    test_send  = 1'b0;
    resend     = 1'b0;
    cfg_sel    = 1'b0;
    tbl0 = '{16'h1280, 16'h1280, 16'h1181, 16'h1204, 16'h0C04, 16'h3E1A, 16'h703A,
             16'h7135, 16'h7233, 16'h73F3, 16'hA202, 16'hA202, 16'hA202, 16'hA202,
             16'hA202, 16'hA202, 16'hA202, 16'hA202, 16'hA202, 16'hA202, 16'hA202,
             16'hA202, 16'h40F0, 16'h0F43, 16'h8C02, 16'h1520, 16'h0E61, 16'h0F4B,
             16'h1602, 16'hFFFF};
    tbl1 = '{16'h1280, 16'h1280, 16'h1204, 16'h40F0, 16'h8C02, 16'h1181, 16'h0F43,
             16'h1520, 16'h0C04, 16'h3E1B, 16'h703A, 16'h71B5, 16'h7233, 16'h73F3,
             16'hA202, 16'hFFFF};
    test_reset_and_xclk();
    test_cfg0_sequence();
    test_cfg_change();
    test_single_step();
    test_back_pressure();
    test_resend();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
